// File: Makefile
VERILATOR ?= verilator
TOP       := regfile_tb
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert
OBJ_DIR   := obj_dir

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the run prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
src/gpr_pkg.sv
src/tag_pkg.sv
src/gpr_ifs.sv
src/gpr_write_decode.sv
src/gpr_slot.sv
src/gpr_read_select.sv
src/regfile_top.sv
test/regfile_checker.sv
test/regfile_tb.sv

// File: src/gpr_ifs.sv
// Write decoder to register slots
interface gpr_load_if import gpr_pkg::*, tag_pkg::*; (
    input logic clk,
    input logic rst_n
);

    sect_mask_t load_mask  [gpr_count];   // Data load per section
    sect_mask_t claim_mask [gpr_count];   // Tag claim per section
    gpr_word_u  wr_word    [gpr_count];   // Already aligned to its lanes
    ptc_id_t    new_ptcid;

    modport decoder (
        input  clk, rst_n,
        output load_mask, claim_mask, wr_word, new_ptcid
    );

    modport slot (
        input load_mask, claim_mask, wr_word, new_ptcid
    );

endinterface

// Register slots to read selector
interface gpr_state_if import gpr_pkg::*, tag_pkg::*; (
    input logic clk,
    input logic rst_n
);

    gpr_word_u       value [gpr_count];
    sect_tag_t [2:0] tag   [gpr_count];   // Indexed by sect_t

    modport slot (
        output value, tag
    );

    modport reader (
        input clk, rst_n, value, tag
    );

endinterface

// File: src/gpr_pkg.sv
package gpr_pkg;

    // ========================================================================
    // Register bank geometry
    // ========================================================================

    localparam int gpr_count = 8;

    typedef logic [2:0] gpr_addr_t;

    // Code 2'b11 is illegal on every port
    typedef enum logic [1:0] {
        SIZE_8  = 2'b00,   // Low byte, or high byte of addr-4 for addr 4 to 7
        SIZE_16 = 2'b01,
        SIZE_32 = 2'b10
    } gpr_size_t;

    // Section index, also the bit position inside a sect_mask_t
    typedef enum logic [1:0] {
        SECT_L = 2'd0,
        SECT_H = 2'd1,
        SECT_E = 2'd2
    } sect_t;

    typedef logic [2:0] sect_mask_t;

    // ========================================================================
    // Register word, seen whole or by section
    // ========================================================================

    typedef struct packed {
        logic [15:0] e;   // Upper 16 bits
        logic [7:0]  h;
        logic [7:0]  l;
    } gpr_sects_t;

    typedef union packed {
        logic [31:0] word;
        gpr_sects_t  sect;
    } gpr_word_u;

endpackage

// File: src/gpr_read_select.sv
module gpr_read_select import gpr_pkg::*, tag_pkg::*; (
    input  gpr_addr_t          rd_addr,
    input  gpr_size_t          rd_size,
    gpr_state_if.reader        state,
    output logic [31:0]        rd_data,
    output logic               rd_busy,
    output ptc_id_t            rd_tag
);

    gpr_addr_t       slot_sel;
    gpr_word_u       word;
    sect_tag_t [2:0] tags;
    sect_mask_t      covered;
    sect_mask_t      pending;

    // Byte addresses 4 to 7 fold onto the high byte of registers 0 to 3
    assign slot_sel = (rd_size == SIZE_8 && rd_addr[2]) ? {1'b0, rd_addr[1:0]} : rd_addr;
    assign word     = state.value[slot_sel];
    assign tags     = state.tag[slot_sel];

    always_comb begin
        covered = '0;
        rd_data = '0;
        case (rd_size)
            SIZE_8: begin
                if (rd_addr[2]) begin
                    covered[SECT_H] = 1'b1;
                    rd_data = {{24{word.sect.h[7]}}, word.sect.h};
                end else begin
                    covered[SECT_L] = 1'b1;
                    rd_data = {{24{word.word[7]}}, word.word[7:0]};
                end
            end
            SIZE_16: begin
                covered[SECT_L] = 1'b1;
                covered[SECT_H] = 1'b1;
                rd_data = {{16{word.word[15]}}, word.word[15:0]};
            end
            SIZE_32: begin
                covered = '1;
                rd_data = word.word;
            end
            default: covered = '0;
        endcase
    end

    assign pending = {tags[SECT_E].pending, tags[SECT_H].pending, tags[SECT_L].pending};
    assign rd_busy = |(pending & covered);

    // Tag of the lowest section that the read covers
    assign rd_tag = covered[SECT_L] ? tags[SECT_L].id : tags[SECT_H].id;

    a_rd_size: assert property (@(posedge state.clk) disable iff (!state.rst_n)
        rd_size inside {SIZE_8, SIZE_16, SIZE_32})
        else $error("illegal read size code");

endmodule

// File: src/gpr_slot.sv
module gpr_slot import gpr_pkg::*, tag_pkg::*; #(
    parameter int slot_index = 0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      done_en,
    input  ptc_id_t   done_ptcid,
    input  logic      flush,
    gpr_load_if.slot  load,
    gpr_state_if.slot state
);

    gpr_word_u       data_q;
    sect_tag_t [2:0] tag_q;
    sect_mask_t      ld_mask;
    sect_mask_t      claim_mask;
    gpr_word_u       wr_word;

    assign ld_mask    = load.load_mask[slot_index];
    assign claim_mask = load.claim_mask[slot_index];
    assign wr_word    = load.wr_word[slot_index];

    // ========================================================================
    // Sections and their tags
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
            tag_q  <= '0;
        end else begin
            if (ld_mask[SECT_L]) data_q.sect.l <= wr_word.sect.l;
            if (ld_mask[SECT_H]) data_q.sect.h <= wr_word.sect.h;
            if (ld_mask[SECT_E]) data_q.sect.e <= wr_word.sect.e;

            for (int s = 0; s < 3; s++) begin
                if (claim_mask[s]) begin   // A new claim beats completion and flush
                    tag_q[s].id      <= load.new_ptcid;
                    tag_q[s].pending <= 1'b1;
                end else if (flush || (done_en && tag_q[s].id == done_ptcid)) begin
                    tag_q[s].pending <= 1'b0;
                end
            end
        end
    end

    assign state.value[slot_index] = data_q;
    assign state.tag[slot_index]   = tag_q;

    // What the reader sees one cycle after a claim must be pending
    for (genvar s = 0; s < 3; s++) begin : g_chk
        a_claim_pending: assert property (@(posedge clk) disable iff (!rst_n)
            claim_mask[s] |=> state.tag[slot_index][s].pending)
            else $error("register %0d section %0d lost its claim", slot_index, s);
    end

endmodule

// File: src/gpr_write_decode.sv
module gpr_write_decode import gpr_pkg::*, tag_pkg::*; (
    input  logic        wr_en,
    input  logic        dest_en,
    input  gpr_addr_t   wr_addr,
    input  gpr_addr_t   dest_addr,
    input  gpr_size_t   wr_size,
    input  gpr_size_t   dest_size,
    input  logic [31:0] wr_data,
    input  ptc_id_t     new_ptcid,
    gpr_load_if.decoder load
);

    gpr_word_u              aligned;
    logic [gpr_count-1:0]   wr_hit;
    logic [gpr_count-1:0]   dest_hit;

    // Sections of one slot covered by an address and size
    function automatic sect_mask_t slot_mask(
        input logic      en,
        input gpr_addr_t addr,
        input gpr_size_t size,
        input gpr_addr_t slot
    );
        sect_mask_t m;
        m = '0;
        if (en) begin
            case (size)
                SIZE_8: begin
                    if (addr[2]) begin
                        if ({1'b0, addr[1:0]} == slot) m[SECT_H] = 1'b1;   // AH, CH, DH, BH
                    end else if (addr == slot) begin
                        m[SECT_L] = 1'b1;
                    end
                end
                SIZE_16: begin
                    if (addr == slot) begin
                        m[SECT_L] = 1'b1;
                        m[SECT_H] = 1'b1;
                    end
                end
                SIZE_32: begin
                    if (addr == slot) m = '1;
                end
                default: m = '0;
            endcase
        end
        return m;
    endfunction

    // A high-byte write takes its data from the low byte of the bus
    always_comb begin
        aligned.word = wr_data;
        if (wr_size == SIZE_8 && wr_addr[2]) aligned.sect.h = wr_data[7:0];
    end

    assign load.new_ptcid = new_ptcid;

    for (genvar i = 0; i < gpr_count; i++) begin : g_slot
        assign load.load_mask[i]  = slot_mask(wr_en, wr_addr, wr_size, gpr_addr_t'(i));
        assign load.claim_mask[i] = slot_mask(dest_en, dest_addr, dest_size, gpr_addr_t'(i));
        assign load.wr_word[i]    = aligned;
        assign wr_hit[i]          = |load.load_mask[i];
        assign dest_hit[i]        = |load.claim_mask[i];
    end

    a_one_slot: assert property (@(posedge load.clk) disable iff (!load.rst_n)
        $onehot0(wr_hit) && $onehot0(dest_hit))
        else $error("write decode selects more than one register");

    a_legal_size: assert property (@(posedge load.clk) disable iff (!load.rst_n)
        (!wr_en || wr_size inside {SIZE_8, SIZE_16, SIZE_32}) &&
        (!dest_en || dest_size inside {SIZE_8, SIZE_16, SIZE_32}))
        else $error("illegal size code on an enabled port");

endmodule

// File: src/regfile_top.sv
module regfile_top import gpr_pkg::*, tag_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  gpr_addr_t   wr_addr,
    input  gpr_size_t   wr_size,
    input  logic [31:0] wr_data,
    input  logic        dest_en,
    input  gpr_addr_t   dest_addr,
    input  gpr_size_t   dest_size,
    input  ptc_id_t     new_ptcid,
    input  logic        done_en,
    input  ptc_id_t     done_ptcid,
    input  logic        flush,
    input  gpr_addr_t   rd_addr,
    input  gpr_size_t   rd_size,
    output logic [31:0] rd_data,
    output logic        rd_busy,
    output ptc_id_t     rd_tag
);

    gpr_load_if  load_bus  (.clk(clk), .rst_n(rst_n));
    gpr_state_if state_bus (.clk(clk), .rst_n(rst_n));

    gpr_write_decode u_decode (
        .wr_en     (wr_en),
        .dest_en   (dest_en),
        .wr_addr   (wr_addr),
        .dest_addr (dest_addr),
        .wr_size   (wr_size),
        .dest_size (dest_size),
        .wr_data   (wr_data),
        .new_ptcid (new_ptcid),
        .load      (load_bus.decoder)
    );

    // ========================================================================
    // EAX .. EDI
    // ========================================================================

    for (genvar i = 0; i < gpr_count; i++) begin : g_gpr
        gpr_slot #(.slot_index(i)) u_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .done_en    (done_en),
            .done_ptcid (done_ptcid),
            .flush      (flush),
            .load       (load_bus.slot),
            .state      (state_bus.slot)
        );
    end

    gpr_read_select u_read (
        .rd_addr (rd_addr),
        .rd_size (rd_size),
        .state   (state_bus.reader),
        .rd_data (rd_data),
        .rd_busy (rd_busy),
        .rd_tag  (rd_tag)
    );

endmodule

// File: src/tag_pkg.sv
package tag_pkg;

    // ========================================================================
    // Rename tags
    // ========================================================================

    localparam int ptc_id_width = 7;

    typedef logic [ptc_id_width-1:0] ptc_id_t;

    // One tag per register section
    typedef struct packed {
        logic    pending;   // Set by a claim, cleared by completion or flush
        ptc_id_t id;
    } sect_tag_t;

endpackage

// File: test/regfile_checker.sv
module regfile_checker import tag_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dest_en,
    input  logic        flush,
    input  logic [31:0] rd_data,
    input  logic [31:0] exp_data,
    input  logic        rd_busy,
    input  logic        exp_busy,
    input  ptc_id_t     rd_tag,
    input  ptc_id_t     exp_tag,
    output logic        mismatch
);

    initial mismatch = 1'b0;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s expected %h actual %h", name, exp, act);
        mismatch = 1'b1;   // Picked up by the testbench top
    endtask

    // ========================================================================
    // Read port against the reference model
    // ========================================================================

    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n) rd_data == exp_data)
        else report_mismatch("rd_data", $sampled(exp_data), $sampled(rd_data));

    a_rd_busy: assert property (@(posedge clk) disable iff (!rst_n) rd_busy == exp_busy)
        else report_mismatch("rd_busy", 32'($sampled(exp_busy)), 32'($sampled(rd_busy)));

    a_rd_tag: assert property (@(posedge clk) disable iff (!rst_n) rd_tag == exp_tag)
        else report_mismatch("rd_tag", 32'($sampled(exp_tag)), 32'($sampled(rd_tag)));

    // Nothing is pending right after reset
    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !rd_busy)
        else report_mismatch("rd_busy", 32'h0, 32'($sampled(rd_busy)));

    // A flush without a claim on the same edge leaves the whole bank idle
    a_flush_idle: assert property (@(posedge clk) disable iff (!rst_n)
        flush && !dest_en |=> !rd_busy)
        else report_mismatch("rd_busy", 32'h0, 32'($sampled(rd_busy)));

endmodule

// File: test/regfile_tb.sv
module regfile_tb import gpr_pkg::*, tag_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    logic        dest_en;
    logic        done_en;
    logic        flush;
    gpr_addr_t   wr_addr;
    gpr_addr_t   dest_addr;
    gpr_addr_t   rd_addr;
    gpr_size_t   wr_size;
    gpr_size_t   dest_size;
    gpr_size_t   rd_size;
    logic [31:0] wr_data;
    logic [31:0] rd_data;
    ptc_id_t     new_ptcid;
    ptc_id_t     done_ptcid;
    ptc_id_t     rd_tag;
    ptc_id_t     last_id;
    logic        rd_busy;
    logic        mismatch;
    logic [15:0] lfsr;

    logic [31:0] m_data [gpr_count];   // Reference model of the bank
    logic [2:0]  m_pend [gpr_count];
    ptc_id_t     m_id   [gpr_count][3];
    logic [31:0] exp_data;
    logic        exp_busy;
    ptc_id_t     exp_tag;

    regfile_top dut0 (.*);

    regfile_checker u_check (
        .clk(clk), .rst_n(rst_n), .dest_en(dest_en), .flush(flush),
        .rd_data(rd_data), .exp_data(exp_data), .rd_busy(rd_busy), .exp_busy(exp_busy),
        .rd_tag(rd_tag), .exp_tag(exp_tag), .mismatch(mismatch)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic draw_size(output gpr_size_t sz);
        logic [31:0] v;
        draw(2, v);
        sz = (v[1:0] == 2'b11) ? SIZE_32 : gpr_size_t'(v[1:0]);
    endtask

    // Section s of register r is part of an access at addr and size
    function automatic logic covers(gpr_addr_t a, gpr_size_t sz, int r, int s);
        case (sz)
            SIZE_8:  return a[2] ? (r == int'(a) - 4 && s == 1) : (r == int'(a) && s == 0);
            SIZE_16: return r == int'(a) && s < 2;
            SIZE_32: return r == int'(a);
            default: return 1'b0;
        endcase
    endfunction

    // ========================================================================
    // Reference model
    // ========================================================================

    always @(posedge clk) begin
        for (int r = 0; r < gpr_count; r++) begin
            if (!rst_n) begin
                m_data[r] <= '0;
                m_pend[r] <= '0;
            end
            for (int s = 0; s < 3; s++) begin
                if (!rst_n) begin
                    m_id[r][s] <= '0;
                end else begin
                    if (wr_en && covers(wr_addr, wr_size, r, s)) begin
                        case (s)
                            0: m_data[r][7:0] <= wr_data[7:0];
                            1: m_data[r][15:8] <= (wr_size == SIZE_8) ? wr_data[7:0]
                                                                        : wr_data[15:8];
                            default: m_data[r][31:16] <= wr_data[31:16];
                        endcase
                    end
                    if (dest_en && covers(dest_addr, dest_size, r, s)) begin
                        m_id[r][s]   <= new_ptcid;
                        m_pend[r][s] <= 1'b1;
                    end else if (flush || (done_en && m_id[r][s] == done_ptcid)) begin
                        m_pend[r][s] <= 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        logic [31:0] v;
        int          r;
        r = (rd_size == SIZE_8 && rd_addr[2]) ? int'(rd_addr) - 4 : int'(rd_addr);
        v = m_data[r];
        exp_busy = 1'b0;
        exp_tag  = '0;
        for (int s = 2; s >= 0; s--) begin
            if (covers(rd_addr, rd_size, r, s)) begin
                exp_busy = exp_busy | m_pend[r][s];
                exp_tag  = m_id[r][s];   // Lowest covered section is seen last
            end
        end
        case (rd_size)
            SIZE_8:  exp_data = rd_addr[2] ? {{24{v[15]}}, v[15:8]} : {{24{v[7]}}, v[7:0]};
            SIZE_16: exp_data = {{16{v[15]}}, v[15:0]};
            default: exp_data = v;
        endcase
    end

    always @(posedge mismatch) begin
        $display("sim failed");
        $fatal(1);
    end

    task automatic idle_inputs();
        wr_en   = 1'b0;
        dest_en = 1'b0;
        done_en = 1'b0;
        flush   = 1'b0;
    endtask

    task automatic sweep_reads();
        for (int a = 0; a < gpr_count; a++) begin
            for (int sz = 0; sz < 3; sz++) begin
                rd_addr = gpr_addr_t'(a);
                rd_size = gpr_size_t'(sz);
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_busy_clear(input int limit);
        int n;
        n = 0;
        while (rd_busy) begin
            if (n == limit) begin
                $display("timed out waiting for rd_busy to clear");
                $display("sim failed");
                $fatal(1);
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic random_cycle();
        logic [31:0] v;
        draw(1, v);
        wr_en = v[0];
        draw(3, v);
        wr_addr = v[2:0];
        draw_size(wr_size);
        draw(32, wr_data);
        draw(2, v);
        dest_en = (v[1:0] == 2'b00);
        draw(3, v);
        dest_addr = v[2:0];
        draw_size(dest_size);
        draw(7, v);
        new_ptcid = v[6:0];
        draw(1, v);
        done_en = v[0];
        draw(1, v);
        if (v[0]) begin
            done_ptcid = last_id;   // Likely to hit a section still pending
        end else begin
            draw(7, v);
            done_ptcid = v[6:0];
        end
        if (dest_en) last_id = new_ptcid;
        draw(4, v);
        flush = (v[3:0] == 4'h0);
        draw(3, v);
        rd_addr = v[2:0];
        draw_size(rd_size);
        @(negedge clk);
    endtask

    initial begin
        lfsr       = 16'd5;
        rst_n      = 1'b0;
        idle_inputs();
        wr_addr    = '0;
        dest_addr  = '0;
        rd_addr    = '0;
        wr_size    = SIZE_8;
        dest_size  = SIZE_8;
        rd_size    = SIZE_8;
        wr_data    = '0;
        new_ptcid  = '0;
        done_ptcid = '0;
        last_id    = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        sweep_reads();

        // BH write seen through a dword read of EBX
        wr_en   = 1'b1;
        wr_addr = 3'd7;
        wr_data = 32'h0000_00a5;
        rd_addr = 3'd3;
        rd_size = SIZE_32;
        @(negedge clk);
        wr_en = 1'b0;
        @(negedge clk);

        // Claim EDX, miss it once, then complete it
        dest_en   = 1'b1;
        dest_addr = 3'd2;
        dest_size = SIZE_32;
        new_ptcid = 7'h11;
        rd_addr   = 3'd2;
        @(negedge clk);
        dest_en    = 1'b0;
        done_en    = 1'b1;
        done_ptcid = 7'h12;
        @(negedge clk);
        done_ptcid = 7'h11;
        @(negedge clk);
        done_en = 1'b0;
        wait_busy_clear(4);

        // Claim and matching completion on one edge
        dest_en = 1'b1;
        done_en = 1'b1;
        @(negedge clk);
        dest_addr = 3'd7;
        dest_size = SIZE_8;
        new_ptcid = 7'h22;
        done_en   = 1'b0;
        flush     = 1'b1;
        rd_addr   = 3'd7;
        rd_size   = SIZE_8;
        @(negedge clk);
        dest_en = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        wait_busy_clear(4);

        repeat (800) random_cycle();
        idle_inputs();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        sweep_reads();

        if (mismatch) begin
            $display("sim failed");
            $fatal(1);
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
